//--- verilog/isaPkg.sv
`default_nettype none

package isaPkg;

    localparam int REG_IDX_WIDTH = 4;
    localparam int STORE_BIT     = 0;    // Bit of the move field that marks a store

    typedef logic [REG_IDX_WIDTH-1:0] regIdx;

    typedef enum logic [1:0] {
        CLASS_IMM    = 2'b00,
        CLASS_REG    = 2'b01,
        CLASS_MEM    = 2'b10,
        CLASS_BRANCH = 2'b11
    } opClass;

    // Second-level codes, flag-setting forms have bit 3 set
    typedef enum logic [3:0] {
        SEC_ADD  = 4'd1,  SEC_SUB  = 4'd2,  SEC_AND = 4'd3, SEC_OR  = 4'd4,
        SEC_XOR  = 4'd5,  SEC_NOT  = 4'd6,
        SEC_ADDS = 4'd9,  SEC_SUBS = 4'd10, SEC_ANDS = 4'd11, SEC_ORS = 4'd12,
        SEC_XORS = 4'd13
    } secondOp;

    typedef enum logic [2:0] {
        MV_MOV = 3'd0, MV_MOVT = 3'd1, MV_CLR = 3'd2,
        MV_SET = 3'd3, MV_LSL  = 3'd4, MV_LSR = 3'd5
    } moveOp;

    typedef enum logic [3:0] {
        COND_EQ = 4'd0, COND_NE, COND_HS, COND_LO, COND_MI, COND_PL, COND_VS,
        COND_VC, COND_HI, COND_LS, COND_GE, COND_LT, COND_GT, COND_LE
    } branchCond;

    typedef struct packed {
        opClass      instrClass;
        logic        special;     // Immediate class only, 1 selects the ALU group
        secondOp     second;
        moveOp       move;
        branchCond   cond;
        logic [15:0] imm;
        regIdx       dest;
        regIdx       srcA;
        regIdx       srcB;
    } instrFields;

endpackage

`default_nettype wire

//--- verilog/execPkg.sv
`default_nettype none

package execPkg;

    localparam int WORD_WIDTH  = 32;
    localparam int IMM_WIDTH   = 16;
    localparam int SHIFT_WIDTH = $clog2(WORD_WIDTH);

    typedef logic [WORD_WIDTH-1:0] word;

    typedef struct packed {
        logic n;
        logic z;
        logic c;
        logic v;
    } nzcv;

    typedef enum logic [3:0] {
        OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_NOT,
        OP_PASSB, OP_MOVT, OP_SHL, OP_SHR, OP_NONE
    } aluOp;

    typedef enum logic [1:0] {
        KEEP,
        NZ_ONLY,     // Logical ops
        NZCV_ALL     // Add and subtract
    } flagMode;

    typedef struct packed {
        aluOp    op;
        flagMode flagSel;
        logic    useImm;
        logic    zeroImm;     // Zero- rather than sign-extend the immediate
        logic    forceZero;   // CLR
        logic    forceOnes;   // SET
        logic    writeBack;
        logic    memRead;
        logic    memWrite;
        logic    isBranch;
    } execCtrl;

endpackage

`default_nettype wire

//--- verilog/executeDecoder.sv
`timescale 1ns/100ps
`default_nettype none

module executeDecoder (
    input  isaPkg::instrFields instr,
    output isaPkg::regIdx      readRegDest,
    output isaPkg::regIdx      readRegFirst,
    output isaPkg::regIdx      readRegSec,
    output execPkg::execCtrl   ctrl
);
    import isaPkg::*;
    import execPkg::*;

    // Second-level group shared by register and immediate forms
    function automatic execCtrl decodeSecond(input secondOp code);
        execCtrl c;
        c           = '0;
        c.op        = OP_NONE;
        c.writeBack = 1'b1;
        case (code)
            SEC_ADD, SEC_ADDS: c.op = OP_ADD;
            SEC_SUB, SEC_SUBS: c.op = OP_SUB;
            SEC_AND, SEC_ANDS: c.op = OP_AND;
            SEC_OR, SEC_ORS:   c.op = OP_OR;
            SEC_XOR, SEC_XORS: c.op = OP_XOR;
            SEC_NOT:           c.op = OP_NOT;
            default:           c.writeBack = 1'b0;    // Unused code does nothing
        endcase
        case (code)
            SEC_ADDS, SEC_SUBS:          c.flagSel = NZCV_ALL;
            SEC_ANDS, SEC_ORS, SEC_XORS: c.flagSel = NZ_ONLY;
            default:                     c.flagSel = KEEP;
        endcase
        return c;
    endfunction

    always_comb begin
        ctrl         = '0;
        ctrl.op      = OP_NONE;
        readRegDest  = '0;
        readRegFirst = '0;
        readRegSec   = '0;
        case (instr.instrClass)
            CLASS_REG: begin
                ctrl = decodeSecond(instr.second);
                if (ctrl.writeBack) begin
                    readRegFirst = instr.srcA;
                    if (ctrl.op != OP_NOT)
                        readRegSec = instr.srcB;    // NOT is unary
                end
            end
            CLASS_IMM: begin
                if (instr.special) begin
                    ctrl        = decodeSecond(instr.second);
                    ctrl.useImm = 1'b1;
                    if (ctrl.writeBack)
                        readRegFirst = instr.srcA;
                end else begin
                    ctrl.useImm    = 1'b1;
                    ctrl.writeBack = 1'b1;
                    case (instr.move)
                        MV_MOV: begin
                            ctrl.op      = OP_PASSB;
                            ctrl.zeroImm = 1'b1;
                        end
                        MV_MOVT: begin
                            ctrl.op     = OP_MOVT;
                            readRegDest = instr.dest;    // Low half is kept
                        end
                        MV_CLR: begin
                            ctrl.op        = OP_PASSB;
                            ctrl.forceZero = 1'b1;
                        end
                        MV_SET: begin
                            ctrl.op        = OP_PASSB;
                            ctrl.forceOnes = 1'b1;
                        end
                        MV_LSL: begin
                            ctrl.op      = OP_SHL;
                            readRegFirst = instr.srcA;
                        end
                        MV_LSR: begin
                            ctrl.op      = OP_SHR;
                            readRegFirst = instr.srcA;
                        end
                        default: ctrl.writeBack = 1'b0;
                    endcase
                end
            end
            CLASS_MEM: begin
                readRegFirst = instr.srcA;    // Base address
                if (instr.move[STORE_BIT]) begin
                    ctrl.memWrite = 1'b1;
                    readRegDest   = instr.dest;    // Store data
                end else begin
                    ctrl.memRead = 1'b1;
                end
            end
            CLASS_BRANCH: ctrl.isBranch = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/integerAlu.sv
`timescale 1ns/100ps
`default_nettype none

module integerAlu (
    input  execPkg::execCtrl              ctrl,
    input  execPkg::word                  opA,
    input  execPkg::word                  opB,
    input  execPkg::word                  destOld,
    input  logic [execPkg::IMM_WIDTH-1:0] imm,
    output execPkg::word                  result,
    output execPkg::nzcv                  candFlags
);
    import execPkg::*;

    word                 operandB;
    logic [WORD_WIDTH:0] sum;     // Extra bit holds the carry
    logic [WORD_WIDTH:0] diff;    // Extra bit holds the borrow

    // Register, extended immediate, or a forced constant
    always_comb begin
        if (ctrl.forceZero)
            operandB = '0;
        else if (ctrl.forceOnes)
            operandB = '1;
        else if (!ctrl.useImm)
            operandB = opB;
        else if (ctrl.zeroImm)
            operandB = {{(WORD_WIDTH-IMM_WIDTH){1'b0}}, imm};
        else
            operandB = {{(WORD_WIDTH-IMM_WIDTH){imm[IMM_WIDTH-1]}}, imm};
    end

    assign sum  = {1'b0, opA} + {1'b0, operandB};
    assign diff = {1'b0, opA} - {1'b0, operandB};

    always_comb begin
        case (ctrl.op)
            OP_ADD:   result = sum[WORD_WIDTH-1:0];
            OP_SUB:   result = diff[WORD_WIDTH-1:0];
            OP_AND:   result = opA & operandB;
            OP_OR:    result = opA | operandB;
            OP_XOR:   result = opA ^ operandB;
            OP_NOT:   result = ~opA;
            OP_PASSB: result = operandB;
            OP_MOVT:  result = {operandB[IMM_WIDTH-1:0], destOld[WORD_WIDTH-IMM_WIDTH-1:0]};
            OP_SHL:   result = opA << operandB[SHIFT_WIDTH-1:0];
            OP_SHR:   result = opA >> operandB[SHIFT_WIDTH-1:0];
            default:  result = '0;
        endcase
    end

    always_comb begin
        candFlags.n = result[WORD_WIDTH-1];
        candFlags.z = (result == '0);
        candFlags.c = 1'b0;
        candFlags.v = 1'b0;
        if (ctrl.op == OP_ADD) begin
            candFlags.c = sum[WORD_WIDTH];
            candFlags.v = (opA[WORD_WIDTH-1] == operandB[WORD_WIDTH-1]) &&
                          (result[WORD_WIDTH-1] != opA[WORD_WIDTH-1]);
        end else if (ctrl.op == OP_SUB) begin
            candFlags.c = ~diff[WORD_WIDTH];    // Not borrow
            candFlags.v = (opA[WORD_WIDTH-1] != operandB[WORD_WIDTH-1]) &&
                          (result[WORD_WIDTH-1] != opA[WORD_WIDTH-1]);
        end
    end

endmodule

`default_nettype wire

//--- verilog/flagRegister.sv
`timescale 1ns/100ps
`default_nettype none

module flagRegister (
    input  logic             clk,
    input  logic             rst,
    input  execPkg::flagMode mode,
    input  execPkg::nzcv     candFlags,
    output execPkg::nzcv     flags
);
    import execPkg::*;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            flags <= '0;
        end else begin
            case (mode)
                NZCV_ALL: flags <= candFlags;
                NZ_ONLY: begin
                    flags.n <= candFlags.n;
                    flags.z <= candFlags.z;
                end
                default: flags <= flags;    // KEEP
            endcase
        end
    end

    // Carry and overflow survive logical ops
    property nzOnlyKeepsCv;
        @(posedge clk) disable iff (rst)
            mode == NZ_ONLY |=> flags.c == $past(flags.c) && flags.v == $past(flags.v);
    endproperty

    assert property (nzOnlyKeepsCv)
        else $error("C or V changed after an NZ_ONLY update");

endmodule

`default_nettype wire

//--- verilog/branchCondition.sv
`timescale 1ns/100ps
`default_nettype none

module branchCondition (
    input  logic              isBranch,
    input  isaPkg::branchCond cond,
    input  execPkg::nzcv      flags,
    output logic              branchTaken
);
    import isaPkg::*;

    logic holds;    // Condition of the even code in the pair

    always_comb begin
        case (cond)
            COND_EQ, COND_NE: holds = flags.z;
            COND_HS, COND_LO: holds = flags.c;
            COND_MI, COND_PL: holds = flags.n;
            COND_VS, COND_VC: holds = flags.v;
            COND_HI, COND_LS: holds = !flags.z && flags.c;      // Unsigned higher
            COND_GE, COND_LT: holds = flags.n == flags.v;
            COND_GT, COND_LE: holds = !flags.z && (flags.n == flags.v);
            default:          holds = 1'b0;
        endcase
    end

    // Odd codes invert, codes past LE never branch
    assign branchTaken = isBranch && (cond <= COND_LE) && (holds ^ cond[0]);

endmodule

`default_nettype wire

//--- verilog/memoryAccessUnit.sv
`timescale 1ns/100ps
`default_nettype none

module memoryAccessUnit (
    input  execPkg::execCtrl              ctrl,
    input  execPkg::word                  base,
    input  execPkg::word                  storeData,
    input  execPkg::word                  memoryDataIn,
    input  execPkg::word                  aluResult,
    input  logic [execPkg::IMM_WIDTH-1:0] offset,
    output execPkg::word                  memoryAddress,
    output execPkg::word                  memoryData,
    output execPkg::word                  writeData,
    output logic                          memoryRead,
    output logic                          memoryWrite,
    output logic                          writeToReg
);
    import execPkg::*;

    word offsetExt;
    word effAddr;

    assign offsetExt = {{(WORD_WIDTH-IMM_WIDTH){offset[IMM_WIDTH-1]}}, offset};
    assign effAddr   = base + offsetExt;

    always_comb begin
        memoryRead    = ctrl.memRead;
        memoryWrite   = ctrl.memWrite;
        memoryAddress = (ctrl.memRead || ctrl.memWrite) ? effAddr : '0;
        memoryData    = ctrl.memWrite ? storeData : '0;    // Bus quiet unless storing
        writeData     = ctrl.memRead ? memoryDataIn : aluResult;
        writeToReg    = ctrl.writeBack || ctrl.memRead;
    end

    // A store never writes the register file
    always_comb begin
        assert (!(ctrl.memWrite && (ctrl.writeBack || ctrl.memRead)))
            else $error("store decoded with a register write-back");
    end

endmodule

`default_nettype wire

//--- verilog/executeStage.sv
`timescale 1ns/100ps
`default_nettype none

module executeStage (
    input  logic               clk,
    input  logic               rst,
    input  isaPkg::instrFields instr,
    input  execPkg::word       readDataDest,
    input  execPkg::word       readDataFirst,
    input  execPkg::word       readDataSec,
    input  execPkg::word       memoryDataIn,
    output isaPkg::regIdx      readRegDest,
    output isaPkg::regIdx      readRegFirst,
    output isaPkg::regIdx      readRegSec,
    output execPkg::word       writeData,
    output logic               writeToReg,
    output logic               branchTaken,
    output execPkg::nzcv       flags,
    output execPkg::word       memoryAddress,
    output execPkg::word       memoryData,
    output logic               memoryRead,
    output logic               memoryWrite
);
    import execPkg::*;

    execCtrl ctrl;
    word     aluResult;
    nzcv     candFlags;

    executeDecoder decoder (
        .instr        (instr),
        .readRegDest  (readRegDest),
        .readRegFirst (readRegFirst),
        .readRegSec   (readRegSec),
        .ctrl         (ctrl)
    );

    integerAlu alu (
        .ctrl      (ctrl),
        .opA       (readDataFirst),
        .opB       (readDataSec),
        .destOld   (readDataDest),    // MOVT keeps its low half
        .imm       (instr.imm),
        .result    (aluResult),
        .candFlags (candFlags)
    );

    flagRegister flagReg (
        .clk       (clk),
        .rst       (rst),
        .mode      (ctrl.flagSel),
        .candFlags (candFlags),
        .flags     (flags)
    );

    // Sees the flags stored by the previous instruction
    branchCondition branchUnit (
        .isBranch    (ctrl.isBranch),
        .cond        (instr.cond),
        .flags       (flags),
        .branchTaken (branchTaken)
    );

    memoryAccessUnit memUnit (
        .ctrl          (ctrl),
        .base          (readDataFirst),
        .storeData     (readDataDest),
        .memoryDataIn  (memoryDataIn),
        .aluResult     (aluResult),
        .offset        (instr.imm),
        .memoryAddress (memoryAddress),
        .memoryData    (memoryData),
        .writeData     (writeData),
        .memoryRead    (memoryRead),
        .memoryWrite   (memoryWrite),
        .writeToReg    (writeToReg)
    );

endmodule

`default_nettype wire

//--- verification/executeChecker.sv
`timescale 1ns/100ps
`default_nettype none

module executeChecker (
    input  logic               clk,
    input  logic               rst,
    input  isaPkg::instrFields instr,
    input  execPkg::word       memoryDataIn,
    input  isaPkg::regIdx      readRegDest,
    input  isaPkg::regIdx      readRegFirst,
    input  isaPkg::regIdx      readRegSec,
    input  execPkg::word       writeData,
    input  logic               writeToReg,
    input  logic               branchTaken,
    input  execPkg::nzcv       flags,
    input  execPkg::word       memoryAddress,
    input  execPkg::word       memoryData,
    input  logic               memoryRead,
    input  logic               memoryWrite,
    output int                 errorCount,
    output int                 checkCount
);
    import isaPkg::*;
    import execPkg::*;

    typedef struct packed {
        regIdx readRegDest;
        regIdx readRegFirst;
        regIdx readRegSec;
        word   writeData;
        logic  writeToReg;
        logic  branchTaken;
        word   memoryAddress;
        word   memoryData;
        logic  memoryRead;
        logic  memoryWrite;
        nzcv   nextFlags;
    } expectation;

    word        regs [16];    // Own copy of the register file
    nzcv        modelFlags;
    expectation expNow;
    expectation expNext;
    string      lastName;

    string aluNames [16] = '{"NOP", "ADD", "SUB", "AND", "OR", "XOR", "NOT", "NOP",
                             "NOP", "ADDS", "SUBS", "ANDS", "ORS", "XORS", "NOP", "NOP"};
    string moveNames [8] = '{"MOV", "MOVT", "CLR", "SET", "LSL", "LSR", "move 6", "move 7"};
    string condNames [16] = '{"EQ", "NE", "HS", "LO", "MI", "PL", "VS", "VC",
                              "HI", "LS", "GE", "LT", "GT", "LE", " 14", " 15"};

    initial begin
        errorCount = 0;
        checkCount = 0;
        for (int i = 0; i < 16; i++)
            regs[i] = 32'h9e37_79b9 * (i + 1);
    end

    function automatic string opName(input instrFields ins);
        case (ins.instrClass)
            CLASS_REG: return {"reg ", aluNames[ins.second]};
            CLASS_IMM: return ins.special ? {"imm ", aluNames[ins.second]} : moveNames[ins.move];
            CLASS_MEM: return ins.move[STORE_BIT] ? "store" : "load";
            default:   return {"B", condNames[ins.cond]};
        endcase
    endfunction

    function automatic logic condHolds(input branchCond c, input nzcv f);
        case (c)
            COND_EQ: return f.z;
            COND_NE: return !f.z;
            COND_HS: return f.c;
            COND_LO: return !f.c;
            COND_MI: return f.n;
            COND_PL: return !f.n;
            COND_VS: return f.v;
            COND_VC: return !f.v;
            COND_HI: return f.c && !f.z;
            COND_LS: return !f.c || f.z;
            COND_GE: return f.n == f.v;
            COND_LT: return f.n != f.v;
            COND_GT: return !f.z && (f.n == f.v);
            COND_LE: return f.z || (f.n != f.v);
            default: return 1'b0;    // Codes 14 and 15 never branch
        endcase
    endfunction

    // Expected outputs and next flags of one instruction
    function automatic expectation refExec(input instrFields ins, input word rA, input word rB,
                                           input word rD, input nzcv f, input word memIn);
        expectation  e;
        word         b;
        word         offset;
        logic [32:0] wide;
        logic [32:0] sx;    // Sign-extended operands for overflow
        logic [2:0]  base;
        e           = '0;
        e.nextFlags = f;
        base        = ins.second[2:0];
        offset      = {{16{ins.imm[15]}}, ins.imm};
        case (ins.instrClass)
            CLASS_REG, CLASS_IMM: begin
                b = (ins.instrClass == CLASS_REG) ? rB : offset;
                if (ins.instrClass == CLASS_IMM && !ins.special) begin
                    e.writeToReg = 1'b1;
                    case (ins.move)
                        MV_MOV:  e.writeData = {16'h0000, ins.imm};
                        MV_MOVT: begin
                            e.writeData   = {ins.imm, rD[15:0]};
                            e.readRegDest = ins.dest;
                        end
                        MV_CLR:  e.writeData = '0;
                        MV_SET:  e.writeData = '1;
                        MV_LSL: begin
                            e.writeData    = rA << ins.imm[4:0];
                            e.readRegFirst = ins.srcA;
                        end
                        MV_LSR: begin
                            e.writeData    = rA >> ins.imm[4:0];
                            e.readRegFirst = ins.srcA;
                        end
                        default: e.writeToReg = 1'b0;
                    endcase
                end else if (base >= 3'd1 && base <= 3'd6 && !(ins.second[3] && base == 3'd6)) begin
                    e.writeToReg   = 1'b1;
                    e.readRegFirst = ins.srcA;
                    if (ins.instrClass == CLASS_REG && base != 3'd6)
                        e.readRegSec = ins.srcB;    // Only binary register forms read srcB
                    wide = (base == 3'd2) ? {1'b0, rA} - {1'b0, b} : {1'b0, rA} + {1'b0, b};
                    sx   = (base == 3'd2) ? {rA[31], rA} - {b[31], b} : {rA[31], rA} + {b[31], b};
                    case (base)
                        3'd1, 3'd2: e.writeData = wide[31:0];
                        3'd3:       e.writeData = rA & b;
                        3'd4:       e.writeData = rA | b;
                        3'd5:       e.writeData = rA ^ b;
                        default:    e.writeData = ~rA;
                    endcase
                    if (ins.second[3]) begin
                        e.nextFlags.n = e.writeData[31];
                        e.nextFlags.z = (e.writeData == '0);
                        if (base <= 3'd2) begin
                            e.nextFlags.c = (base == 3'd1) ? wide[32] : (rA >= b);    // No borrow
                            e.nextFlags.v = sx[32] ^ sx[31];
                        end
                    end
                end
            end
            CLASS_MEM: begin
                e.memoryAddress = rA + offset;
                e.readRegFirst  = ins.srcA;
                if (ins.move[STORE_BIT]) begin
                    e.memoryWrite = 1'b1;
                    e.memoryData  = rD;
                    e.readRegDest = ins.dest;
                end else begin
                    e.memoryRead = 1'b1;
                    e.writeToReg = 1'b1;
                    e.writeData  = memIn;
                end
            end
            default: e.branchTaken = condHolds(ins.cond, f);
        endcase
        return e;
    endfunction

    task automatic checkValue(input string testName, input string signalName,
                              input word expected, input word actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("FAILED %s %s: expected %h, actual %h",
                     testName, signalName, expected, actual);
        end
    endtask

    // Flag and register models advance with the DUT
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            modelFlags <= '0;
            lastName = "reset";
        end else begin
            expNext = refExec(instr, regs[instr.srcA], regs[instr.srcB], regs[instr.dest],
                              modelFlags, memoryDataIn);
            modelFlags <= expNext.nextFlags;
            if (expNext.writeToReg)
                regs[instr.dest] <= expNext.writeData;
            lastName = opName(instr);
        end
    end

    always @(negedge clk) begin
        expNow = refExec(instr, regs[instr.srcA], regs[instr.srcB], regs[instr.dest],
                         modelFlags, memoryDataIn);
        checkValue(opName(instr), "readRegDest", word'(expNow.readRegDest), word'(readRegDest));
        checkValue(opName(instr), "readRegFirst", word'(expNow.readRegFirst),
                   word'(readRegFirst));
        checkValue(opName(instr), "readRegSec", word'(expNow.readRegSec), word'(readRegSec));
        checkValue(opName(instr), "writeToReg", word'(expNow.writeToReg), word'(writeToReg));
        checkValue(opName(instr), "memoryRead", word'(expNow.memoryRead), word'(memoryRead));
        checkValue(opName(instr), "memoryWrite", word'(expNow.memoryWrite), word'(memoryWrite));
        checkValue(opName(instr), "branchTaken", word'(expNow.branchTaken), word'(branchTaken));
        checkValue({"flags after ", lastName}, "flags", word'(modelFlags), word'(flags));
        if (expNow.writeToReg)
            checkValue(opName(instr), "writeData", expNow.writeData, writeData);
        if (expNow.memoryRead || expNow.memoryWrite)
            checkValue(opName(instr), "memoryAddress", expNow.memoryAddress, memoryAddress);
        if (expNow.memoryWrite)
            checkValue(opName(instr), "memoryData", expNow.memoryData, memoryData);
    end

endmodule

`default_nettype wire

//--- verification/executeStageTb.sv
`timescale 1ns/100ps
`default_nettype none

module executeStageTb;
    import isaPkg::*;
    import execPkg::*;

    localparam int RESET_CYCLES  = 16;
    localparam int ALU_CYCLES    = 44;        // Eleven codes four times each
    localparam int MOVE_CYCLES   = 24;
    localparam int SETUP_CYCLES  = 7;
    localparam int BRANCH_CYCLES = 7 * 15;    // Flag setup then all fourteen codes
    localparam int MEM_CYCLES    = 20;
    localparam int RANDOM_CYCLES = 200;
    localparam int TOTAL_CYCLES  = RESET_CYCLES + ALU_CYCLES + MOVE_CYCLES + SETUP_CYCLES
                                 + BRANCH_CYCLES + MEM_CYCLES + RANDOM_CYCLES + 3;
    localparam int CYCLE_LIMIT   = TOTAL_CYCLES + 100;

    logic       clk = 1'b0;
    logic       rst;
    instrFields instr;
    word        readDataDest, readDataFirst, readDataSec, memoryDataIn;
    regIdx      readRegDest, readRegFirst, readRegSec;
    word        writeData, memoryAddress, memoryData;
    logic       writeToReg, branchTaken, memoryRead, memoryWrite;
    nzcv        flags;
    word        regFile [16];
    int         errorCount, checkCount;
    int         cycleCount = 0;

    secondOp aluCodes [11] = '{SEC_ADD, SEC_SUB, SEC_AND, SEC_OR, SEC_XOR, SEC_NOT,
                               SEC_ADDS, SEC_SUBS, SEC_ANDS, SEC_ORS, SEC_XORS};
    moveOp   moveCodes [6] = '{MV_MOV, MV_MOVT, MV_CLR, MV_SET, MV_LSL, MV_LSR};

    executeStage uut (.*);

    executeChecker scoreboard (.*);

    initial begin
        forever #50 clk = ~clk;
    end

    // Register file model with combinational reads
    initial begin
        for (int i = 0; i < 16; i++)
            regFile[i] = 32'h9e37_79b9 * (i + 1);
    end

    assign readDataDest  = regFile[readRegDest];
    assign readDataFirst = regFile[readRegFirst];
    assign readDataSec   = regFile[readRegSec];

    always @(posedge clk) begin
        if (!rst && writeToReg)
            regFile[instr.dest] <= writeData;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CYCLE_LIMIT) begin
            $display("Run did not finish within the cycle limit of %0d", CYCLE_LIMIT);
            $display("Simulation failed");
            $finish;
        end
    end

    // Unused register-form code that decodes to no operation
    function automatic instrFields idleInstr();
        instrFields i;
        i            = '0;
        i.instrClass = CLASS_REG;
        return i;
    endfunction

    function automatic instrFields aluInstr(input logic immForm, input secondOp code,
                                            input regIdx d, input regIdx a, input regIdx b,
                                            input logic [15:0] imm);
        instrFields i;
        i = '0;
        if (immForm)
            i.instrClass = CLASS_IMM;
        else
            i.instrClass = CLASS_REG;
        i.special = 1'b1;
        i.second  = code;
        i.dest    = d;
        i.srcA    = a;
        i.srcB    = b;
        i.imm     = imm;
        return i;
    endfunction

    function automatic instrFields moveInstr(input moveOp code, input regIdx d, input regIdx a,
                                             input logic [15:0] imm);
        instrFields i;
        i            = '0;
        i.instrClass = CLASS_IMM;
        i.move       = code;
        i.dest       = d;
        i.srcA       = a;
        i.imm        = imm;
        return i;
    endfunction

    function automatic instrFields memInstr(input logic store, input regIdx d, input regIdx base,
                                            input logic [15:0] offset);
        instrFields i;
        logic [2:0] m;
        i            = '0;
        m            = '0;
        m[STORE_BIT] = store;
        i.instrClass = CLASS_MEM;
        i.move       = moveOp'(m);
        i.dest       = d;
        i.srcA       = base;
        i.imm        = offset;
        return i;
    endfunction

    function automatic instrFields branchInstr(input int code);
        instrFields i;
        i            = '0;
        i.instrClass = CLASS_BRANCH;
        i.cond       = branchCond'(4'(code));
        return i;
    endfunction

    // Operands prepared in r2 to r6 and result dumped in r7
    function automatic instrFields flagSetup(input int s);
        case (s)
            0:       return aluInstr(1'b0, SEC_SUBS, 4'd7, 4'd3, 4'd3, '0);    // Z and C
            1:       return aluInstr(1'b0, SEC_ADDS, 4'd7, 4'd2, 4'd2, '0);    // N and C
            2:       return aluInstr(1'b0, SEC_ADDS, 4'd7, 4'd5, 4'd4, '0);    // N and V
            3:       return aluInstr(1'b0, SEC_SUBS, 4'd7, 4'd3, 4'd4, '0);    // N with borrow
            4:       return aluInstr(1'b0, SEC_ADDS, 4'd7, 4'd4, 4'd4, '0);    // All clear
            5:       return aluInstr(1'b0, SEC_SUBS, 4'd7, 4'd6, 4'd4, '0);    // C and V
            default: return aluInstr(1'b0, SEC_ADDS, 4'd7, 4'd6, 4'd6, '0);    // Z, C and V
        endcase
    endfunction

    function automatic instrFields randomInstr();
        logic [63:0] r;
        r = {$urandom(), $urandom()};
        return r[$bits(instrFields)-1:0];
    endfunction

    task automatic issue(input instrFields ins);
        @(posedge clk);
        instr        <= ins;
        memoryDataIn <= $urandom();
    endtask

    initial begin
        logic [31:0] r;
        void'($urandom(32'ha2a4_dc22));
        rst          = 1'b1;
        instr        = idleInstr();
        memoryDataIn = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;

        for (int k = 0; k < ALU_CYCLES; k++) begin
            r = $urandom();
            issue(aluInstr(k[0], aluCodes[k / 4], r[3:0], r[7:4], r[11:8], r[31:16]));
        end
        for (int k = 0; k < MOVE_CYCLES; k++) begin
            r = $urandom();
            issue(moveInstr(moveCodes[k % 6], r[3:0], r[7:4], r[31:16]));
        end

        issue(moveInstr(MV_SET, 4'd2, 4'd0, 16'h0000));
        issue(moveInstr(MV_CLR, 4'd3, 4'd0, 16'h0000));
        issue(moveInstr(MV_MOV, 4'd4, 4'd0, 16'h0001));
        issue(moveInstr(MV_MOV, 4'd5, 4'd0, 16'hffff));
        issue(moveInstr(MV_MOVT, 4'd5, 4'd0, 16'h7fff));    // Largest positive word
        issue(moveInstr(MV_CLR, 4'd6, 4'd0, 16'h0000));
        issue(moveInstr(MV_MOVT, 4'd6, 4'd0, 16'h8000));    // Most negative word
        for (int s = 0; s < 7; s++) begin
            issue(flagSetup(s));
            for (int c = 0; c < 14; c++)
                issue(branchInstr(c));
        end

        for (int k = 0; k < MEM_CYCLES; k++) begin
            r = $urandom();
            issue(memInstr(r[0], r[7:4], r[11:8], r[31:16]));
        end
        for (int k = 0; k < RANDOM_CYCLES; k++)
            issue(randomInstr());

        issue(idleInstr());
        repeat (2) @(posedge clk);    // Last flags and outputs checked
        $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
verilog/isaPkg.sv
verilog/execPkg.sv
verilog/executeDecoder.sv
verilog/integerAlu.sv
verilog/flagRegister.sv
verilog/branchCondition.sv
verilog/memoryAccessUnit.sv
verilog/executeStage.sv
verification/executeChecker.sv
verification/executeStageTb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/100ps
TOP      = executeStageTb
FILELIST = tb.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then exit 1; fi
	@grep -q "Simulation passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
